//--- source/muldiv_pkg.sv
package muldiv_pkg;

    // *******************************************************************
    // Data widths
    // *******************************************************************

    typedef logic [31:0] word_t;    // Operand or result word
    typedef logic [63:0] dword_t;   // Full product
    typedef logic [2:0]  funct3_t;  // Operation code
    typedef logic [3:0]  tag_t;     // Caller's operation tag

    // *******************************************************************
    // M extension funct3 codes
    // *******************************************************************

    // Bit 2 set selects the divider
    localparam funct3_t FN_MUL    = 3'd0;
    localparam funct3_t FN_MULH   = 3'd1;
    localparam funct3_t FN_MULHSU = 3'd2;
    localparam funct3_t FN_MULHU  = 3'd3;
    localparam funct3_t FN_DIV    = 3'd4;
    localparam funct3_t FN_DIVU   = 3'd5;
    localparam funct3_t FN_REM    = 3'd6;
    localparam funct3_t FN_REMU   = 3'd7;

    // *******************************************************************
    // Timing
    // *******************************************************************

    // Issue edge to result_valid_o for a multiply
    localparam int MUL_LATENCY = 3;

    // One quotient bit per step
    localparam int DIV_STEPS = 32;

    // Divider control
    typedef enum logic [1:0] {
        DS_IDLE = 2'd0,
        DS_CALC = 2'd1,
        DS_SIGN = 2'd2,
        DS_DONE = 2'd3
    } div_state_e;

endpackage

//--- source/mul_pipe.sv
`timescale 1ns/1ns

module mul_pipe (
    input  logic                clk,
    input  logic                reset,
    input  logic                issue_i,
    input  muldiv_pkg::funct3_t op_i,
    input  muldiv_pkg::word_t   operand_a_i,
    input  muldiv_pkg::word_t   operand_b_i,
    input  muldiv_pkg::tag_t    tag_i,
    output logic                mul_valid_o,
    output muldiv_pkg::word_t   mul_result_o,
    output muldiv_pkg::tag_t    mul_tag_o
);

    logic                s1_valid;
    muldiv_pkg::funct3_t s1_op;
    muldiv_pkg::tag_t    s1_tag;
    logic signed [63:0]  s1_a;
    logic signed [63:0]  s1_b;

    logic                a_signed;
    logic                b_signed;
    muldiv_pkg::dword_t  product;

    // rs1 is signed for MULH and MULHSU, rs2 only for MULH
    assign a_signed = (op_i == muldiv_pkg::FN_MULH) || (op_i == muldiv_pkg::FN_MULHSU);
    assign b_signed = (op_i == muldiv_pkg::FN_MULH);

    // Stage 1, extended operands
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_i && !op_i[2];
        end
    end

    always_ff @(posedge clk) begin
        s1_op  <= op_i;
        s1_tag <= tag_i;
        s1_a   <= {{32{a_signed && operand_a_i[31]}}, operand_a_i};
        s1_b   <= {{32{b_signed && operand_b_i[31]}}, operand_b_i};
    end

    // Low 64 bits are exact for every sign mix
    assign product = s1_a * s1_b;

    // Stage 2, word select
    always_ff @(posedge clk) begin
        if (reset) begin
            mul_valid_o <= 1'b0;
        end else begin
            mul_valid_o <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        mul_tag_o    <= s1_tag;
        mul_result_o <= (s1_op == muldiv_pkg::FN_MUL) ? product[31:0] : product[63:32];
    end

endmodule

//--- source/div_iter.sv
`timescale 1ns/1ns

module div_iter (
    input  logic                clk,
    input  logic                reset,
    input  logic                issue_i,
    input  muldiv_pkg::funct3_t op_i,
    input  muldiv_pkg::word_t   operand_a_i,
    input  muldiv_pkg::word_t   operand_b_i,
    input  muldiv_pkg::tag_t    tag_i,
    input  logic                grant_i,
    output logic                busy_o,
    output logic                div_valid_o,
    output muldiv_pkg::word_t   div_result_o,
    output muldiv_pkg::tag_t    div_tag_o
);

    muldiv_pkg::div_state_e state;
    logic [$clog2(muldiv_pkg::DIV_STEPS)-1:0] step_cnt;

    muldiv_pkg::funct3_t op_q;
    muldiv_pkg::tag_t    tag_q;
    muldiv_pkg::word_t   divisor_q;
    muldiv_pkg::word_t   quo_q;
    muldiv_pkg::word_t   rem_q;
    logic                neg_a_q;
    logic                signs_differ_q;
    muldiv_pkg::word_t   result_q;

    logic                start;
    logic                is_signed;
    logic                neg_a;
    logic                neg_b;
    muldiv_pkg::word_t   mag_a;
    muldiv_pkg::word_t   mag_b;
    logic                div_by_zero;
    logic                overflow;

    logic [32:0]         rem_shift;
    logic [32:0]         diff;
    muldiv_pkg::word_t   quo_fix;
    muldiv_pkg::word_t   rem_fix;

    // *******************************************************************
    // Issue decode
    // *******************************************************************

    assign start     = issue_i && op_i[2] && (state == muldiv_pkg::DS_IDLE);
    assign is_signed = !op_i[0];    // DIV and REM

    assign neg_a = is_signed && operand_a_i[31];
    assign neg_b = is_signed && operand_b_i[31];
    assign mag_a = neg_a ? -operand_a_i : operand_a_i;
    assign mag_b = neg_b ? -operand_b_i : operand_b_i;

    assign div_by_zero = (operand_b_i == '0);
    assign overflow    = is_signed && (operand_a_i == 32'h8000_0000) && (operand_b_i == '1);

    // *******************************************************************
    // Restoring step
    // *******************************************************************

    assign rem_shift = {rem_q, quo_q[31]};
    assign diff      = rem_shift - {1'b0, divisor_q};   // Bit 32 set means no fit

    assign quo_fix = signs_differ_q ? -quo_q : quo_q;
    assign rem_fix = neg_a_q ? -rem_q : rem_q;          // Remainder follows the dividend

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= muldiv_pkg::DS_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                muldiv_pkg::DS_IDLE: begin
                    step_cnt <= '0;
                    if (start) begin
                        if (div_by_zero || overflow) begin
                            state <= muldiv_pkg::DS_DONE;
                        end else begin
                            state <= muldiv_pkg::DS_CALC;
                        end
                    end
                end
                muldiv_pkg::DS_CALC: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == ($bits(step_cnt))'(muldiv_pkg::DIV_STEPS - 1)) begin
                        state <= muldiv_pkg::DS_SIGN;
                    end
                end
                muldiv_pkg::DS_SIGN: state <= muldiv_pkg::DS_DONE;
                muldiv_pkg::DS_DONE: begin
                    if (grant_i) begin
                        state <= muldiv_pkg::DS_IDLE;
                    end
                end
                default: state <= muldiv_pkg::DS_IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (start) begin
            op_q           <= op_i;
            tag_q          <= tag_i;
            neg_a_q        <= neg_a;
            signs_differ_q <= neg_a ^ neg_b;
            divisor_q      <= mag_b;
            quo_q          <= mag_a;    // Dividend bits shift out as quotient bits shift in
            rem_q          <= '0;
            if (div_by_zero) begin
                result_q <= op_i[1] ? operand_a_i : '1;
            end else if (overflow) begin
                result_q <= op_i[1] ? '0 : operand_a_i;
            end
        end else if (state == muldiv_pkg::DS_CALC) begin
            quo_q <= {quo_q[30:0], ~diff[32]};
            rem_q <= diff[32] ? rem_shift[31:0] : diff[31:0];
        end else if (state == muldiv_pkg::DS_SIGN) begin
            result_q <= op_q[1] ? rem_fix : quo_fix;    // REM and REMU
        end
    end

    assign busy_o       = (state != muldiv_pkg::DS_IDLE);
    assign div_valid_o  = (state == muldiv_pkg::DS_DONE);
    assign div_result_o = result_q;
    assign div_tag_o    = tag_q;

endmodule

//--- source/result_arbiter.sv
`timescale 1ns/1ns

module result_arbiter (
    input  logic              clk,
    input  logic              reset,
    input  logic              mul_valid_i,
    input  muldiv_pkg::word_t mul_result_i,
    input  muldiv_pkg::tag_t  mul_tag_i,
    input  logic              div_valid_i,
    input  muldiv_pkg::word_t div_result_i,
    input  muldiv_pkg::tag_t  div_tag_i,
    output logic              div_grant_o,
    output logic              result_valid_o,
    output muldiv_pkg::word_t result_o,
    output muldiv_pkg::tag_t  result_tag_o
);

    // *******************************************************************
    // Fixed priority, the multiplier cannot stall
    // *******************************************************************

    assign div_grant_o = div_valid_i && !mul_valid_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= mul_valid_i || div_valid_i;   // One pulse per winner
        end
    end

    // Result and tag registers
    always_ff @(posedge clk) begin
        if (mul_valid_i) begin
            result_o     <= mul_result_i;
            result_tag_o <= mul_tag_i;
        end else begin
            result_o     <= div_result_i;
            result_tag_o <= div_tag_i;
        end
    end

endmodule

//--- source/muldiv_unit.sv
`timescale 1ns/1ns

module muldiv_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                issue_i,
    input  muldiv_pkg::funct3_t op_i,
    input  muldiv_pkg::word_t   operand_a_i,
    input  muldiv_pkg::word_t   operand_b_i,
    input  muldiv_pkg::tag_t    tag_i,
    output logic                div_busy_o,
    output logic                result_valid_o,
    output muldiv_pkg::word_t   result_o,
    output muldiv_pkg::tag_t    result_tag_o
);

    logic              mul_valid;
    muldiv_pkg::word_t mul_result;
    muldiv_pkg::tag_t  mul_tag;

    logic              div_valid;
    muldiv_pkg::word_t div_result;
    muldiv_pkg::tag_t  div_tag;
    logic              div_grant;

    // Both engines see every issue and decode op_i bit 2 themselves
    mul_pipe u_mul_pipe (
        .clk          (clk),
        .reset        (reset),
        .issue_i      (issue_i),
        .op_i         (op_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .tag_i        (tag_i),
        .mul_valid_o  (mul_valid),
        .mul_result_o (mul_result),
        .mul_tag_o    (mul_tag)
    );

    div_iter u_div_iter (
        .clk          (clk),
        .reset        (reset),
        .issue_i      (issue_i),
        .op_i         (op_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .tag_i        (tag_i),
        .grant_i      (div_grant),
        .busy_o       (div_busy_o),
        .div_valid_o  (div_valid),
        .div_result_o (div_result),
        .div_tag_o    (div_tag)
    );

    result_arbiter u_result_arbiter (
        .clk            (clk),
        .reset          (reset),
        .mul_valid_i    (mul_valid),
        .mul_result_i   (mul_result),
        .mul_tag_i      (mul_tag),
        .div_valid_i    (div_valid),
        .div_result_i   (div_result),
        .div_tag_i      (div_tag),
        .div_grant_o    (div_grant),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .result_tag_o   (result_tag_o)
    );

endmodule

//--- testbench/muldiv_sva.sv
`timescale 1ns/1ns

module muldiv_sva (
    input logic                clk,
    input logic                reset,
    input logic                issue_i,
    input muldiv_pkg::funct3_t op_i,
    input logic                div_busy_i,
    input logic                result_valid_i,
    input logic                mul_valid_i,
    input logic                div_valid_i,
    input logic                div_grant_i
);

    // *******************************************************************
    // Issue and result protocol
    // *******************************************************************

    no_div_while_busy: assert property (@(posedge clk) disable iff (reset)
        issue_i && op_i[2] |-> !div_busy_i)
        else $error("Divide issued while the divider is busy");

    mul_fixed_latency: assert property (@(posedge clk) disable iff (reset)
        issue_i && !op_i[2] |-> ##(muldiv_pkg::MUL_LATENCY) result_valid_i)
        else $error("Multiply result missing at its fixed latency");

    div_valid_held: assert property (@(posedge clk) disable iff (reset)
        div_valid_i && !div_grant_i |=> div_valid_i)
        else $error("Divider result dropped without a grant");

    quiet_in_reset: assert property (@(posedge clk)
        reset |=> !result_valid_i && !div_busy_i && !mul_valid_i && !div_valid_i)
        else $error("Valid or busy signal high during reset");

endmodule

bind muldiv_unit muldiv_sva u_muldiv_sva (
    .clk            (clk),
    .reset          (reset),
    .issue_i        (issue_i),
    .op_i           (op_i),
    .div_busy_i     (div_busy_o),
    .result_valid_i (result_valid_o),
    .mul_valid_i    (mul_valid),
    .div_valid_i    (div_valid),
    .div_grant_i    (div_grant)
);

//--- testbench/muldiv_checker.sv
`timescale 1ns/1ns

module muldiv_checker (
    input logic                clk,
    input logic                reset,
    input logic                issue_i,
    input muldiv_pkg::funct3_t op_i,
    input muldiv_pkg::word_t   operand_a_i,
    input muldiv_pkg::word_t   operand_b_i,
    input muldiv_pkg::tag_t    tag_i,
    input logic                result_valid_i,
    input muldiv_pkg::word_t   result_i,
    input muldiv_pkg::tag_t    result_tag_i
);

    muldiv_pkg::word_t expected_q [16];
    logic              pending_q  [16];
    int                checks      = 0;
    int                errors      = 0;
    int                outstanding = 0;

    // ISA rules for the M extension, special cases included
    function automatic muldiv_pkg::word_t expected_result(input muldiv_pkg::funct3_t op,
                                                          input muldiv_pkg::word_t a,
                                                          input muldiv_pkg::word_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] ua;
        logic signed [63:0] ub;
        muldiv_pkg::dword_t p;
        logic               ovf;
        muldiv_pkg::word_t  r;
        sa  = {{32{a[31]}}, a};
        sb  = {{32{b[31]}}, b};
        ua  = {32'd0, a};
        ub  = {32'd0, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        r   = '0;
        case (op)
            muldiv_pkg::FN_MUL: begin
                p = sa * sb;
                r = p[31:0];
            end
            muldiv_pkg::FN_MULH: begin
                p = sa * sb;
                r = p[63:32];
            end
            muldiv_pkg::FN_MULHSU: begin
                p = sa * ub;
                r = p[63:32];
            end
            muldiv_pkg::FN_MULHU: begin
                p = ua * ub;
                r = p[63:32];
            end
            muldiv_pkg::FN_DIV: begin
                if (b == '0) r = '1;
                else if (ovf) r = a;
                else r = $signed(a) / $signed(b);   // Truncates toward zero
            end
            muldiv_pkg::FN_DIVU: begin
                if (b == '0) r = '1;
                else r = a / b;
            end
            muldiv_pkg::FN_REM: begin
                if (b == '0) r = a;
                else if (ovf) r = '0;
                else r = $signed(a) % $signed(b);   // Sign of the dividend
            end
            default: begin
                if (b == '0) r = a;
                else r = a % b;
            end
        endcase
        return r;
    endfunction

    initial begin
        for (int i = 0; i < 16; i++) begin
            pending_q[i] = 1'b0;
        end
    end

    // Results first, so a tag can be reused in the cycle it returns
    always @(posedge clk) begin
        if (!reset) begin
            if (result_valid_i) begin
                if (!pending_q[result_tag_i]) begin
                    $display("Result returned for tag %0d with no operation outstanding",
                             result_tag_i);
                    errors++;
                end else begin
                    checks++;
                    outstanding--;
                    pending_q[result_tag_i] = 1'b0;
                    if (result_i !== expected_q[result_tag_i]) begin
                        $display("Mismatch at %0t: tag %0d got %h expected %h", $time,
                                 result_tag_i, result_i, expected_q[result_tag_i]);
                        errors++;
                    end
                end
            end
            if (issue_i) begin
                if (pending_q[tag_i]) begin
                    $display("Tag %0d issued again while still outstanding", tag_i);
                    errors++;
                end else begin
                    outstanding++;
                end
                pending_q[tag_i]  = 1'b1;
                expected_q[tag_i] = expected_result(op_i, operand_a_i, operand_b_i);
            end
        end
    end

endmodule

//--- testbench/tb_muldiv.sv
`timescale 1ns/1ns

module tb_muldiv;

    // Random ops are counted as divides for the bound
    localparam int N_DIV          = 38 + 300;
    localparam int N_MUL          = 127;
    localparam int TIMEOUT_CYCLES = N_DIV * 40 + N_MUL * 4 + 200;

    logic                clk = 1'b0;
    logic                reset = 1'b1;
    logic                issue_i = 1'b0;
    muldiv_pkg::funct3_t op_i = '0;
    muldiv_pkg::word_t   operand_a_i = '0;
    muldiv_pkg::word_t   operand_b_i = '0;
    muldiv_pkg::tag_t    tag_i = '0;
    logic                div_busy_o;
    logic                result_valid_o;
    muldiv_pkg::word_t   result_o;
    muldiv_pkg::tag_t    result_tag_o;

    muldiv_pkg::tag_t    next_tag = '0;
    muldiv_pkg::tag_t    div_tag = '0;
    logic                div_out = 1'b0;    // Divide issued, result not yet seen
    logic [31:0]         seed = 32'h9b4b3c07;
    int                  cycle_count = 0;
    int                  tb_errors = 0;
    int                  last_checks = 0;
    int                  last_errors = 0;

    muldiv_pkg::word_t corners [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    muldiv_pkg::word_t div_a   [6] = '{32'd7, 32'hffff_fff9, 32'd7, 32'hffff_fff9, 32'd100,
                                       32'hffff_ffff};
    muldiv_pkg::word_t div_b   [6] = '{32'd2, 32'd2, 32'hffff_fffe, 32'hffff_fffe,
                                       32'hffff_fff9, 32'd3};

    always #50 clk = ~clk;

    muldiv_unit u_muldiv_unit (
        .clk(clk), .reset(reset), .issue_i(issue_i), .op_i(op_i),
        .operand_a_i(operand_a_i), .operand_b_i(operand_b_i), .tag_i(tag_i),
        .div_busy_o(div_busy_o), .result_valid_o(result_valid_o),
        .result_o(result_o), .result_tag_o(result_tag_o)
    );

    muldiv_checker u_checker (
        .clk(clk), .reset(reset), .issue_i(issue_i), .op_i(op_i),
        .operand_a_i(operand_a_i), .operand_b_i(operand_b_i), .tag_i(tag_i),
        .result_valid_i(result_valid_o), .result_i(result_o), .result_tag_i(result_tag_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Starts and ends on a falling edge
    task automatic send_op(input muldiv_pkg::funct3_t op, input muldiv_pkg::word_t a,
                           input muldiv_pkg::word_t b);
        if (op[2]) begin
            while (div_busy_o || div_out) @(negedge clk);
        end
        if (div_out && next_tag == div_tag) next_tag = next_tag + 4'd1;   // Skip the live divide
        issue_i     = 1'b1;
        op_i        = op;
        operand_a_i = a;
        operand_b_i = b;
        tag_i       = next_tag;
        if (op[2]) begin
            div_out = 1'b1;
            div_tag = next_tag;
        end
        next_tag = next_tag + 4'd1;
        @(negedge clk);
        issue_i = 1'b0;
    endtask

    task automatic finish_test(input string name);
        while (u_checker.outstanding != 0) @(negedge clk);
        $display("Test %s: %0d results checked, %0d errors", name,
                 u_checker.checks - last_checks, u_checker.errors - last_errors);
        last_checks = u_checker.checks;
        last_errors = u_checker.errors;
    endtask

    always @(posedge clk) begin
        if (div_out && result_valid_o && result_tag_o == div_tag) div_out = 1'b0;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // *******************************************************************
        // Directed tests
        // *******************************************************************
        for (int k = 0; k < 4; k++)
            for (int i = 0; i < 5; i++)
                for (int j = 0; j < 5; j++) send_op(3'(k), corners[i], corners[j]);
        finish_test("mul_corners");

        for (int k = 4; k < 8; k++)
            for (int i = 0; i < 6; i++) send_op(3'(k), div_a[i], div_b[i]);
        finish_test("div_signs");

        for (int k = 4; k < 8; k++) begin
            send_op(3'(k), 32'd5, 32'd0);
            send_op(3'(k), 32'hffff_fffb, 32'd0);
            send_op(3'(k), 32'h8000_0000, 32'hffff_ffff);   // Overflow for signed ops
        end
        finish_test("div_special");

        send_op(muldiv_pkg::FN_DIV, 32'hffff_0000, 32'd13);
        for (int i = 0; i < 24; i++) begin
            seed = lcg_next(seed);
            send_op({1'b0, seed[1:0]}, seed, lcg_next(seed));
        end
        finish_test("mul_back_to_back");

        // Divide result ready in the same cycle as a multiply result
        send_op(muldiv_pkg::FN_MULHU, 32'hdead_beef, 32'h1234_5678);
        send_op(muldiv_pkg::FN_REM, 32'h0000_0042, 32'd0);
        send_op(muldiv_pkg::FN_MUL, 32'd3, 32'd5);
        send_op(muldiv_pkg::FN_MULH, 32'h8000_0000, 32'd2);
        finish_test("mul_div_collision");

        // *******************************************************************
        // Random mix
        // *******************************************************************
        for (int i = 0; i < 300; i++) begin
            muldiv_pkg::word_t a;
            muldiv_pkg::word_t b;
            seed = lcg_next(seed);
            a    = lcg_next(seed);
            b    = lcg_next(a);
            if (seed[9:7] == 3'd0) b = '0;
            else if (seed[9:7] == 3'd1) b = {28'd0, b[3:0]};
            send_op(seed[2:0], a, b);
            if (seed[12]) @(negedge clk);
        end
        finish_test("random_mix");

        if (div_busy_o) begin
            $display("div_busy_o still high after the random test");
            tb_errors++;
        end
        $display("Summary: %0d results checked, %0d errors", u_checker.checks,
                 u_checker.errors + tb_errors);
        if (u_checker.errors + tb_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
source/muldiv_pkg.sv
source/mul_pipe.sv
source/div_iter.sv
source/result_arbiter.sv
source/muldiv_unit.sv
testbench/muldiv_sva.sv
testbench/muldiv_checker.sv
testbench/tb_muldiv.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the muldiv testbench with Verilator

verilator --binary --timing --assert --top-module tb_muldiv -f tb.f -o sim_muldiv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_muldiv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
exit 0
